// ==== all.f ====
rtl/ep0Pkg.sv
rtl/setupCapture.sv
rtl/requestDecoder.sv
rtl/descriptorRom.sv
rtl/controlSequencer.sv
rtl/deviceStateTracker.sv
rtl/ep0Top.sv
tb/ep0Tb.sv

// ==== tb/ep0Golden.txt ====
# name, setup bytes 0..7 (hex), stall, byte count, reply bytes (hex)
# then expected device address and configuration after the status stage (hex)
devDesc64    80 06 00 01 00 00 40 00  0 18
    12 01 00 02 00 00 00 08 34 12 78 56
    00 01 00 00 00 01
    00 00
getStatus    80 00 00 00 00 00 02 00  1 0
    00 00
setConfDflt  00 09 01 00 00 00 00 00  1 0
    00 00
setAddress5  00 05 05 00 00 00 00 00  0 0
    05 00
cfgDesc9     80 06 00 02 00 00 09 00  0 9
    09 02 19 00 01 01 00 80 32
    05 00
setConfig1   00 09 01 00 00 00 00 00  0 0
    05 01
getConfig    80 08 00 00 00 00 01 00  0 1
    01
    05 01
cfgDescFull  80 06 00 02 00 00 ff 00  0 25
    09 02 19 00 01 01 00 80 32
    09 04 00 00 01 ff 00 00 00
    07 05 81 02 40 00 00
    05 01

// ==== tb/ep0Tb.sv ====
`timescale 1ns/100ps

module ep0Tb;
    import ep0Pkg::*;

    logic                clk12_i = 1'b0;
    logic                rstN_i;
    logic                usbResetDetected_i;
    logic                tokenValid_i;
    logic [1:0]          tokenPid_i;
    logic                setupByteValid_i;
    logic [7:0]          setupByte_i;
    logic                transDone_i;
    logic                transSuccess_i;
    logic                txPop_i;
    logic                setupFull_o;
    logic [7:0]          txData_o;
    logic                txAvailable_o;
    logic                txLast_o;
    logic                respValid_o;
    logic                respHandshake_o;
    logic [1:0]          respPid_o;
    logic [ADDR_WID-1:0] deviceAddr_o;
    logic [CONF_WID-1:0] deviceConf_o;
    logic                resetDataToggle_o;

    // Current record from the golden file
    string               testName;
    logic [7:0]          setupBytes [8];
    logic [7:0]          replyBytes [32];
    int                  byteCount;
    int                  recordsRead = 0;
    int                  cycleCount = 0;
    int                  togglePulses = 0;
    logic [31:0]         lfsr = 32'd86422;

    ep0Top dut0 (.*);

    // 20 ns period
    always #10 clk12_i = ~clk12_i;

    // Sampled mid-cycle so the pulse is seen once
    always @(negedge clk12_i) begin
        if (resetDataToggle_o) begin
            togglePulses = togglePulses + 1;
        end
    end

    always @(posedge clk12_i) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > 400 * recordsRead + 100) begin
            $display("Timeout: no progress after %0d cycles in %s", cycleCount, testName);
            $display("** FAIL **");
            $fatal(1, "run stopped on timeout");
        end
    end

    // ==================================================================
    // Compare tasks
    // ==================================================================

    task automatic reportMismatch(input string what, input logic [15:0] expV,
                                  input logic [15:0] actV);
        $display("** Error %s: %s expected %0h, actual %0h", testName, what, expV, actV);
        $display("** FAIL **");
        $fatal(1, "mismatch");
    endtask

    task automatic checkByte(input string what, input logic [7:0] expV, input logic [7:0] actV);
        if (expV !== actV) reportMismatch(what, expV, actV);
    endtask

    task automatic checkPid(input string what, input logic [1:0] expV, input logic [1:0] actV);
        if (expV !== actV) reportMismatch(what, expV, actV);
    endtask

    task automatic checkAddr(input string what, input logic [ADDR_WID-1:0] expV,
                             input logic [ADDR_WID-1:0] actV);
        if (expV !== actV) reportMismatch(what, expV, actV);
    endtask

    task automatic checkConf(input string what, input logic [CONF_WID-1:0] expV,
                             input logic [CONF_WID-1:0] actV);
        if (expV !== actV) reportMismatch(what, expV, actV);
    endtask

    task automatic checkFlag(input string what, input logic expV, input logic actV);
        if (expV !== actV) reportMismatch(what, expV, actV);
    endtask

    // ==================================================================
    // Host side driver
    // ==================================================================

    // Galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
    endfunction

    task automatic randBits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val  = (val << 1) | lfsr[0];
            lfsr = lfsrNext(lfsr);
        end
    endtask

    // Inputs change 2 ns after the edge, outputs are read there too
    task automatic nextCycle();
        @(posedge clk12_i);
        #2;
    endtask

    task automatic awaitResp();
        while (!respValid_o) nextCycle();
    endtask

    task automatic sendToken(input logic [1:0] pid);
        tokenValid_i = 1'b1;
        tokenPid_i   = pid;
        nextCycle();
        tokenValid_i = 1'b0;
        awaitResp();
    endtask

    task automatic endTrans(input logic ok);
        transDone_i    = 1'b1;
        transSuccess_i = ok;
        nextCycle();
        transDone_i    = 1'b0;
        transSuccess_i = 1'b0;
    endtask

    task automatic runSetup();
        sendToken(TOKEN_SETUP);
        for (int i = 0; i < 8; i++) begin
            setupByteValid_i = 1'b1;
            setupByte_i      = setupBytes[i];
            nextCycle();
        end
        setupByteValid_i = 1'b0;
        checkFlag("setup full", 1'b1, setupFull_o);
        endTrans(1'b1);
        nextCycle();
        awaitResp();
    endtask

    // Random back-pressure before every pop
    task automatic popBytes(input int first, input int n);
        int idle;
        for (int k = first; k < first + n; k++) begin
            randBits(2, idle);
            repeat (idle) nextCycle();
            while (!txAvailable_o) nextCycle();
            checkByte("reply byte", replyBytes[k], txData_o);
            checkFlag("last byte flag", k == byteCount - 1, txLast_o);
            txPop_i = 1'b1;
            nextCycle();
            txPop_i = 1'b0;
        end
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial begin
        int                  fd;
        int                  stall;
        int                  sent;
        int                  n;
        int                  failTarget;
        int                  dataRecs;
        int                  expPulses;
        logic                toggle;
        logic                failNow;
        logic [ADDR_WID-1:0] expAddr;
        logic [ADDR_WID-1:0] prevAddr;
        logic [CONF_WID-1:0] expConf;
        string               tok;
        string               line;

        rstN_i             = 1'b0;
        usbResetDetected_i = 1'b0;
        tokenValid_i       = 1'b0;
        tokenPid_i         = TOKEN_OUT;
        setupByteValid_i   = 1'b0;
        setupByte_i        = 8'd0;
        transDone_i        = 1'b0;
        transSuccess_i     = 1'b0;
        txPop_i            = 1'b0;
        testName           = "reset";
        dataRecs           = 0;
        expPulses          = 0;
        prevAddr           = '0;
        repeat (2) @(posedge clk12_i);
        #2;
        rstN_i = 1'b1;
        checkFlag("tx available after reset", 1'b0, txAvailable_o);
        checkFlag("resp valid after reset", 1'b1, respValid_o);
        checkAddr("address after reset", '0, deviceAddr_o);
        randBits(2, failTarget);

        fd = $fopen("tb/ep0Golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file tb/ep0Golden.txt");
            $display("** FAIL **");
            $fatal(1, "no stimulus");
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok[0] == "#") begin
                void'($fgets(line, fd));
                continue;
            end
            testName = tok;
            for (int i = 0; i < 8; i++) void'($fscanf(fd, "%h", setupBytes[i]));
            void'($fscanf(fd, "%d %d", stall, byteCount));
            for (int i = 0; i < byteCount; i++) void'($fscanf(fd, "%h", replyBytes[i]));
            void'($fscanf(fd, "%h %h", expAddr, expConf));
            recordsRead = recordsRead + 1;
            if (setupBytes[1] == REQ_SET_CONFIGURATION && stall == 0) begin
                expPulses = expPulses + 1;
            end

            runSetup();
            if (byteCount == 0) begin
                // Status stage straight away, zero-length IN
                sendToken(TOKEN_IN);
                checkFlag("status handshake", stall != 0, respHandshake_o);
                checkPid("status PID", stall != 0 ? RESP_STALL : RESP_DATA1, respPid_o);
                checkAddr("address before status end", prevAddr, deviceAddr_o);
                endTrans(stall == 0);
            end else begin
                failNow = dataRecs == failTarget;
                dataRecs = dataRecs + 1;
                sent   = 0;
                toggle = 1'b1;
                // Packets of at most 8 bytes
                while (sent < byteCount) begin
                    n = (byteCount - sent > 8) ? 8 : byteCount - sent;
                    sendToken(TOKEN_IN);
                    checkFlag("data handshake", 1'b0, respHandshake_o);
                    checkPid("data PID", toggle ? RESP_DATA1 : RESP_DATA0, respPid_o);
                    popBytes(sent, n);
                    if (failNow) begin
                        endTrans(1'b0);
                        failNow = 1'b0;
                    end else begin
                        endTrans(1'b1);
                        sent   = sent + n;
                        toggle = !toggle;
                    end
                end
                sendToken(TOKEN_OUT);
                checkFlag("status handshake", 1'b1, respHandshake_o);
                checkPid("status PID", RESP_ACK, respPid_o);
                endTrans(1'b1);
            end
            nextCycle();
            checkAddr("device address", expAddr, deviceAddr_o);
            checkConf("device configuration", expConf, deviceConf_o);
            checkByte("toggle reset pulses", expPulses[7:0], togglePulses[7:0]);
            prevAddr = expAddr;
        end
        $fclose(fd);

        // Bus reset in the middle of a device descriptor read
        testName   = "busReset";
        setupBytes = '{8'h80, 8'h06, 8'h00, 8'h01, 8'h00, 8'h00, 8'h40, 8'h00};
        byteCount  = 18;
        replyBytes[0] = 8'h12;
        replyBytes[1] = 8'h01;
        runSetup();
        sendToken(TOKEN_IN);
        popBytes(0, 2);
        usbResetDetected_i = 1'b1;
        nextCycle();
        usbResetDetected_i = 1'b0;
        checkFlag("tx available after bus reset", 1'b0, txAvailable_o);
        checkAddr("address after bus reset", '0, deviceAddr_o);
        checkConf("configuration after bus reset", '0, deviceConf_o);

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== rtl/ep0Top.sv ====
`timescale 1ns/100ps

module ep0Top (
    input  logic                        clk12_i,
    input  logic                        rstN_i,
    input  logic                        usbResetDetected_i,
    input  logic                        tokenValid_i,
    input  logic [1:0]                  tokenPid_i,
    input  logic                        setupByteValid_i,
    input  logic [7:0]                  setupByte_i,
    input  logic                        transDone_i,
    input  logic                        transSuccess_i,
    input  logic                        txPop_i,
    output logic                        setupFull_o,
    output logic [7:0]                  txData_o,
    output logic                        txAvailable_o,
    output logic                        txLast_o,
    output logic                        respValid_o,
    output logic                        respHandshake_o,
    output logic [1:0]                  respPid_o,
    output logic [ep0Pkg::ADDR_WID-1:0] deviceAddr_o,
    output logic [ep0Pkg::CONF_WID-1:0] deviceConf_o,
    output logic                        resetDataToggle_o
);
    import ep0Pkg::*;

    SetupPacket             setupPacket;
    DeviceState             devState;
    logic                   captureClear;
    logic                   decodeEn;
    logic                   reqError;
    logic                   reqFromRom;
    logic [ROM_IDX_WID-1:0] reqRomBase;
    logic [15:0]            reqByteCount;
    logic                   reqDevToHost;
    logic                   reqIsSetAddress;
    logic                   reqIsSetConfig;
    logic [ROM_IDX_WID-1:0] romIdx;
    logic [7:0]             romData;
    logic                   addrCommit;
    logic                   confCommit;

    // Capture stage
    setupCapture capture0 (
        .clk12_i        (clk12_i),
        .rstN_i         (rstN_i),
        .captureClear_i (captureClear),
        .byteValid_i    (setupByteValid_i),
        .byte_i         (setupByte_i),
        .packet_o       (setupPacket),
        .full_o         (setupFull_o)
    );

    // Decode stage
    requestDecoder decoder0 (
        .clk12_i           (clk12_i),
        .rstN_i            (rstN_i),
        .decodeEn_i        (decodeEn),
        .packet_i          (setupPacket),
        .devState_i        (devState),
        .reqError_o        (reqError),
        .reqFromRom_o      (reqFromRom),
        .reqRomBase_o      (reqRomBase),
        .reqByteCount_o    (reqByteCount),
        .reqDevToHost_o    (reqDevToHost),
        .reqIsSetAddress_o (reqIsSetAddress),
        .reqIsSetConfig_o  (reqIsSetConfig)
    );

    descriptorRom rom0 (
        .clk12_i (clk12_i),
        .idx_i   (romIdx),
        .data_o  (romData)
    );

    // Device state beside the pipeline
    deviceStateTracker tracker0 (
        .clk12_i           (clk12_i),
        .rstN_i            (rstN_i),
        .usbReset_i        (usbResetDetected_i),
        .addrCommit_i      (addrCommit),
        .confCommit_i      (confCommit),
        .wValue_i          (setupPacket.fields.wValue),
        .state_o           (devState),
        .deviceAddr_o      (deviceAddr_o),
        .deviceConf_o      (deviceConf_o),
        .resetDataToggle_o (resetDataToggle_o)
    );

    controlSequencer sequencer0 (
        .clk12_i           (clk12_i),
        .rstN_i            (rstN_i),
        .usbReset_i        (usbResetDetected_i),
        .tokenValid_i      (tokenValid_i),
        .tokenPid_i        (tokenPid_i),
        .transDone_i       (transDone_i),
        .transSuccess_i    (transSuccess_i),
        .txPop_i           (txPop_i),
        .romData_i         (romData),
        .deviceConf_i      (deviceConf_o),
        .reqError_i        (reqError),
        .reqFromRom_i      (reqFromRom),
        .reqRomBase_i      (reqRomBase),
        .reqByteCount_i    (reqByteCount),
        .reqDevToHost_i    (reqDevToHost),
        .reqIsSetAddress_i (reqIsSetAddress),
        .reqIsSetConfig_i  (reqIsSetConfig),
        .captureClear_o    (captureClear),
        .decodeEn_o        (decodeEn),
        .romIdx_o          (romIdx),
        .addrCommit_o      (addrCommit),
        .confCommit_o      (confCommit),
        .txData_o          (txData_o),
        .txAvailable_o     (txAvailable_o),
        .txLast_o          (txLast_o),
        .respValid_o       (respValid_o),
        .respHandshake_o   (respHandshake_o),
        .respPid_o         (respPid_o)
    );

endmodule

// ==== rtl/deviceStateTracker.sv ====
`timescale 1ns/100ps

module deviceStateTracker (
    input  logic                        clk12_i,
    input  logic                        rstN_i,
    input  logic                        usbReset_i,
    input  logic                        addrCommit_i,
    input  logic                        confCommit_i,
    input  logic [15:0]                 wValue_i,
    output ep0Pkg::DeviceState          state_o,
    output logic [ep0Pkg::ADDR_WID-1:0] deviceAddr_o,
    output logic [ep0Pkg::CONF_WID-1:0] deviceConf_o,
    output logic                        resetDataToggle_o
);
    import ep0Pkg::*;

    logic [ADDR_WID-1:0] newAddr;
    logic [CONF_WID-1:0] newConf;

    assign newAddr = wValue_i[ADDR_WID-1:0];
    assign newConf = wValue_i[CONF_WID-1:0];

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            state_o           <= devDefault;
            deviceAddr_o      <= '0;
            deviceConf_o      <= '0;
            resetDataToggle_o <= 1'b0;
        end else begin
            resetDataToggle_o <= 1'b0;
            if (usbReset_i) begin
                state_o      <= devDefault;
                deviceAddr_o <= '0;
                deviceConf_o <= '0;
            end else if (addrCommit_i) begin
                // Address zero drops back to default
                deviceAddr_o <= newAddr;
                state_o      <= (newAddr == '0) ? devDefault : devAddressed;
            end else if (confCommit_i) begin
                deviceConf_o      <= newConf;
                state_o           <= (newConf == '0) ? devAddressed : devConfigured;
                resetDataToggle_o <= 1'b1;
            end
        end
    end

    // The sequencer never commits address and configuration together
    a_commitsExclusive: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        addrCommit_i |-> !confCommit_i);

endmodule

// ==== rtl/controlSequencer.sv ====
`timescale 1ns/100ps

module controlSequencer (
    input  logic                           clk12_i,
    input  logic                           rstN_i,
    input  logic                           usbReset_i,
    input  logic                           tokenValid_i,
    input  logic [1:0]                     tokenPid_i,
    input  logic                           transDone_i,
    input  logic                           transSuccess_i,
    input  logic                           txPop_i,
    input  logic [7:0]                     romData_i,
    input  logic [ep0Pkg::CONF_WID-1:0]    deviceConf_i,
    input  logic                           reqError_i,
    input  logic                           reqFromRom_i,
    input  logic [ep0Pkg::ROM_IDX_WID-1:0] reqRomBase_i,
    input  logic [15:0]                    reqByteCount_i,
    input  logic                           reqDevToHost_i,
    input  logic                           reqIsSetAddress_i,
    input  logic                           reqIsSetConfig_i,
    output logic                           captureClear_o,
    output logic                           decodeEn_o,
    output logic [ep0Pkg::ROM_IDX_WID-1:0] romIdx_o,
    output logic                           addrCommit_o,
    output logic                           confCommit_o,
    output logic [7:0]                     txData_o,
    output logic                           txAvailable_o,
    output logic                           txLast_o,
    output logic                           respValid_o,
    output logic                           respHandshake_o,
    output logic [1:0]                     respPid_o
);
    import ep0Pkg::*;

    CtrlStage               stage;
    logic                   loadReq;
    logic                   awaitRom;
    logic                   lastIn;
    logic                   dataToggle;
    logic [ROM_IDX_WID-1:0] transIdx;
    logic [ROM_IDX_WID-1:0] commitIdx;
    logic [ROM_IDX_WID-1:0] idxNow;
    logic [15:0]            transLeft;
    logic [15:0]            commitLeft;
    logic [15:0]            leftNow;
    logic                   popFire;
    logic                   inDone;
    logic                   dirChange;
    logic                   romWait;
    logic                   errActive;

    // First cycle after decode reads straight from the decoder registers
    assign idxNow  = loadReq ? reqRomBase_i : transIdx;
    assign leftNow = loadReq ? reqByteCount_i : transLeft;

    assign popFire   = txPop_i && txAvailable_o;
    assign inDone    = transDone_i && lastIn && stage == stData;
    assign dirChange = tokenValid_i && ((tokenPid_i == TOKEN_IN) != reqDevToHost_i);
    assign romWait   = awaitRom || (loadReq && reqFromRom_i);
    assign errActive = reqError_i && (stage == stData || stage == stStatus);

    assign captureClear_o = stage == stIdle;
    assign decodeEn_o     = stage == stSetup && transDone_i && transSuccess_i;
    // New address only after the status stage went through
    assign addrCommit_o   = stage == stStatus && transDone_i && transSuccess_i &&
                            reqIsSetAddress_i && !reqError_i;
    assign confCommit_o   = loadReq && reqIsSetConfig_i && !reqError_i;
    assign romIdx_o       = idxNow;

    assign txData_o      = reqFromRom_i ? romData_i : deviceConf_i;
    assign txAvailable_o = !romWait && leftNow != 16'd0;
    assign txLast_o      = leftNow == 16'd1;
    assign respValid_o   = !romWait;

    // Handshake for OUT and for stalls, otherwise a DATA PID
    assign respHandshake_o = errActive || !lastIn;

    always_comb begin
        if (errActive) begin
            respPid_o = RESP_STALL;
        end else if (!lastIn) begin
            respPid_o = RESP_ACK;
        end else if (stage == stStatus || dataToggle) begin
            respPid_o = RESP_DATA1;
        end else begin
            respPid_o = RESP_DATA0;
        end
    end

    // ===================================================================
    // Control transfer FSM
    // ===================================================================

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            stage   <= stIdle;
            loadReq <= 1'b0;
        end else if (usbReset_i) begin
            stage   <= stIdle;
            loadReq <= 1'b0;
        end else begin
            loadReq <= decodeEn_o;
            case (stage)
                stIdle: begin
                    if (tokenValid_i && tokenPid_i == TOKEN_SETUP) begin
                        stage <= stSetup;
                    end
                end
                stSetup: begin
                    if (transDone_i) begin
                        stage <= transSuccess_i ? stData : stIdle;
                    end
                end
                stData: begin
                    // No data stage, or the host turned the direction around
                    if ((loadReq && reqByteCount_i == 16'd0) || dirChange) begin
                        stage <= stStatus;
                    end
                end
                default: begin
                    if (transDone_i) begin
                        stage <= stIdle;
                    end
                end
            endcase
        end
    end

    // ===================================================================
    // Read index with commit and rollback
    // ===================================================================

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            awaitRom   <= 1'b0;
            lastIn     <= 1'b1;
            dataToggle <= 1'b1;
            transIdx   <= '0;
            commitIdx  <= '0;
            transLeft  <= 16'd0;
            commitLeft <= 16'd0;
        end else begin
            awaitRom  <= 1'b0;
            transIdx  <= idxNow;
            transLeft <= leftNow;
            if (tokenValid_i) begin
                lastIn <= tokenPid_i == TOKEN_IN;
            end
            // Data stage always opens with DATA1
            if (loadReq) begin
                commitIdx  <= reqRomBase_i;
                commitLeft <= reqByteCount_i;
                dataToggle <= 1'b1;
            end
            if (usbReset_i || stage != stData || dirChange) begin
                transLeft  <= 16'd0;
                commitLeft <= 16'd0;
            end else if (popFire) begin
                transLeft <= leftNow - 16'd1;
                // Index stays on the last byte so it never leaves the ROM
                transIdx  <= idxNow + ROM_IDX_WID'(leftNow != 16'd1);
                awaitRom  <= 1'b1;
            end else if (inDone && transSuccess_i) begin
                commitIdx  <= transIdx;
                commitLeft <= transLeft;
                dataToggle <= !dataToggle;
            end else if (inDone) begin
                // Host missed the packet, replay from the last commit
                transIdx  <= commitIdx;
                transLeft <= commitLeft;
                awaitRom  <= 1'b1;
            end
        end
    end

    a_noTxInIdle: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        stage == stIdle |-> !txAvailable_o);

endmodule

// ==== rtl/descriptorRom.sv ====
`timescale 1ns/100ps

module descriptorRom (
    input  logic                           clk12_i,
    input  logic [ep0Pkg::ROM_IDX_WID-1:0] idx_i,
    output logic [7:0]                     data_o
);
    import ep0Pkg::*;

    logic [7:0] romMem [ROM_SIZE];

    assign romMem = '{
        // Device: USB 2.0, class per interface, 8-byte EP0
        DEVICE_DESC_LEN[7:0], DESC_DEVICE, 8'h00, 8'h02, 8'h00, 8'h00,
        8'h00, 8'h08, 8'h34, 8'h12, 8'h78, 8'h56,
        // bcdDevice, no strings
        8'h00, 8'h01, 8'h00, 8'h00, 8'h00, NUM_CONFIGURATIONS,
        // Configuration 1, bus powered, 100 mA
        8'h09, DESC_CONFIGURATION, CONFIG_DESC_LEN[7:0], CONFIG_DESC_LEN[15:8],
        8'h01, 8'h01, 8'h00, 8'h80, 8'h32,
        // Interface 0, vendor class, one endpoint
        8'h09, 8'h04, 8'h00, 8'h00, 8'h01, 8'hff, 8'h00, 8'h00, 8'h00,
        // Bulk IN endpoint 1, 64-byte packets
        8'h07, 8'h05, 8'h81, 8'h02, 8'h40, 8'h00, 8'h00
    };

    always_ff @(posedge clk12_i) begin
        data_o <= romMem[idx_i];
    end

    // Sequencer must never step past the configuration descriptor
    a_idxInRange: assert property (@(posedge clk12_i) idx_i < ROM_SIZE);

endmodule

// ==== rtl/requestDecoder.sv ====
`timescale 1ns/100ps

module requestDecoder (
    input  logic                           clk12_i,
    input  logic                           rstN_i,
    input  logic                           decodeEn_i,
    input  ep0Pkg::SetupPacket             packet_i,
    input  ep0Pkg::DeviceState             devState_i,
    output logic                           reqError_o,
    output logic                           reqFromRom_o,
    output logic [ep0Pkg::ROM_IDX_WID-1:0] reqRomBase_o,
    output logic [15:0]                    reqByteCount_o,
    output logic                           reqDevToHost_o,
    output logic                           reqIsSetAddress_o,
    output logic                           reqIsSetConfig_o
);
    import ep0Pkg::*;

    SetupFields             f;
    logic                   stdDevice;
    logic                   dirIn;
    logic                   error;
    logic                   fromRom;
    logic [ROM_IDX_WID-1:0] romBase;
    logic [15:0]            descLen;
    logic [15:0]            clipped;
    logic [15:0]            byteCount;

    assign f = packet_i.fields;

    // Standard type and device recipient, direction checked per request
    assign stdDevice = f.bmRequestType[6:0] == 7'd0;
    assign dirIn     = f.bmRequestType[7];

    always_comb begin
        error   = 1'b1;
        fromRom = 1'b0;
        romBase = DEVICE_DESC_BASE;
        descLen = 16'd0;
        case (f.bRequest)
            REQ_SET_ADDRESS: begin
                error = dirIn || devState_i == devConfigured || f.wValue > 16'd127;
            end
            REQ_SET_CONFIGURATION: begin
                error = dirIn || devState_i == devDefault ||
                        f.wValue > {8'd0, NUM_CONFIGURATIONS};
            end
            REQ_GET_CONFIGURATION: begin
                error   = !dirIn || devState_i == devDefault;
                descLen = 16'd1;
            end
            REQ_GET_DESCRIPTOR: begin
                fromRom = 1'b1;
                // High byte is the type, low byte the index
                if (f.wValue[15:8] == DESC_DEVICE) begin
                    error   = !dirIn;
                    descLen = DEVICE_DESC_LEN;
                end else if (f.wValue == {DESC_CONFIGURATION, 8'd0}) begin
                    error   = !dirIn;
                    romBase = CONFIG_DESC_BASE;
                    descLen = CONFIG_DESC_LEN;
                end
            end
            default: begin
                error = 1'b1;
            end
        endcase
        if (!stdDevice) begin
            error = 1'b1;
        end
        // Host may ask for less than the full descriptor
        clipped   = (f.wLength < descLen) ? f.wLength : descLen;
        byteCount = error ? 16'd0 : (fromRom ? clipped : descLen);
    end

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            reqError_o        <= 1'b0;
            reqFromRom_o      <= 1'b0;
            reqRomBase_o      <= DEVICE_DESC_BASE;
            reqByteCount_o    <= 16'd0;
            reqDevToHost_o    <= 1'b0;
            reqIsSetAddress_o <= 1'b0;
            reqIsSetConfig_o  <= 1'b0;
        end else if (decodeEn_i) begin
            reqError_o        <= error;
            reqFromRom_o      <= fromRom && !error;
            reqRomBase_o      <= romBase;
            reqByteCount_o    <= byteCount;
            reqDevToHost_o    <= dirIn;
            reqIsSetAddress_o <= f.bRequest == REQ_SET_ADDRESS;
            reqIsSetConfig_o  <= f.bRequest == REQ_SET_CONFIGURATION;
        end
    end

endmodule

// ==== rtl/setupCapture.sv ====
`timescale 1ns/100ps

module setupCapture (
    input  logic               clk12_i,
    input  logic               rstN_i,
    input  logic               captureClear_i,
    input  logic               byteValid_i,
    input  logic [7:0]         byte_i,
    output ep0Pkg::SetupPacket packet_o,
    output logic               full_o
);
    import ep0Pkg::*;

    // Bit 3 set means all eight bytes are in
    logic [3:0] byteIdx;
    logic       take;

    assign take   = byteValid_i && !full_o;
    assign full_o = byteIdx[3];

    always_ff @(posedge clk12_i or negedge rstN_i) begin
        if (!rstN_i) begin
            byteIdx <= 4'd0;
        end else if (captureClear_i) begin
            byteIdx <= 4'd0;
        end else if (take) begin
            byteIdx <= byteIdx + 4'd1;
        end
    end

    // Packet contents need no reset, full_o qualifies them
    always_ff @(posedge clk12_i) begin
        if (take) begin
            packet_o.bytes[byteIdx[2:0]] <= byte_i;
        end
    end

    // A setup data packet carries exactly eight bytes
    a_noByteWhileFull: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        byteValid_i |-> !full_o);

endmodule

// ==== rtl/ep0Pkg.sv ====
package ep0Pkg;

    // ===================================================================
    // Setup packet
    // ===================================================================

    // Byte 0 sits in the low bits, so the 16-bit fields stay little-endian
    typedef struct packed {
        logic [15:0] wLength;
        logic [15:0] wIndex;
        logic [15:0] wValue;
        logic [7:0]  bRequest;
        logic [7:0]  bmRequestType;
    } SetupFields;

    // Filled bytewise by the capture stage, read as fields by the decoder
    typedef union packed {
        logic [7:0][7:0] bytes;
        SetupFields      fields;
    } SetupPacket;

    typedef enum logic [1:0] {
        devDefault,
        devAddressed,
        devConfigured
    } DeviceState;

    typedef enum logic [1:0] {
        stIdle,
        stSetup,
        stData,
        stStatus
    } CtrlStage;

    // ===================================================================
    // Protocol codes
    // ===================================================================

    localparam logic [7:0] REQ_GET_CONFIGURATION = 8'd8;
    localparam logic [7:0] REQ_GET_DESCRIPTOR    = 8'd6;
    localparam logic [7:0] REQ_SET_ADDRESS       = 8'd5;
    localparam logic [7:0] REQ_SET_CONFIGURATION = 8'd9;

    localparam logic [7:0] DESC_DEVICE        = 8'd1;
    localparam logic [7:0] DESC_CONFIGURATION = 8'd2;

    // Upper two PID bits, the lower two are fixed per group
    localparam logic [1:0] TOKEN_OUT   = 2'b00;
    localparam logic [1:0] TOKEN_IN    = 2'b10;
    localparam logic [1:0] TOKEN_SETUP = 2'b11;

    localparam logic [1:0] RESP_ACK   = 2'b00;
    localparam logic [1:0] RESP_STALL = 2'b11;
    localparam logic [1:0] RESP_DATA0 = 2'b00;
    localparam logic [1:0] RESP_DATA1 = 2'b10;

    // ===================================================================
    // Descriptor ROM layout
    // ===================================================================

    localparam int ROM_SIZE    = 43;
    localparam int ROM_IDX_WID = 6;

    localparam logic [15:0] DEVICE_DESC_LEN = 16'd18;
    localparam logic [15:0] CONFIG_DESC_LEN = 16'd25;

    localparam logic [ROM_IDX_WID-1:0] DEVICE_DESC_BASE = 6'd0;
    localparam logic [ROM_IDX_WID-1:0] CONFIG_DESC_BASE = 6'd18;

    localparam logic [7:0] NUM_CONFIGURATIONS = 8'd1;

    localparam int ADDR_WID = 7;
    localparam int CONF_WID = 8;

endpackage
